// ==== all.f ====
+incdir+hw
hw/dl_pkg.sv
hw/ioctl_router.sv
hw/cart_loader.sv
hw/cheat_assembler.sv
hw/dl_top.sv
sim/dl_props.sv
sim/tb_dl_top.sv

// ==== hw/cart_loader.sv ====
// ==============================
// One write in flight, host must honor ioctl_wait
// Memory acks by copying rom_req
// ==============================
`include "dl_defs.svh"

module cart_loader (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  dl_pkg::dl_beat_t     beat,
	input  logic                 cart_download,
	input  logic                 rom_ack,
	input  logic [`ROM_AW-1:0]   rom_raddr,
	output logic                 ioctl_wait,
	output logic                 rom_req,
	output logic [`ROM_AW-1:0]   rom_waddr,
	output logic [7:0]           rom_wdata,
	output logic [`ROM_AW-1:0]   mem_raddr,
	output dl_pkg::cart_info_t   cart_info
);
	import dl_pkg::*;

	logic               cart_q;
	logic               cart_beat;
	logic [`ROM_AW-1:0] beat_a;
	logic [`ROM_AW-1:0] end_a;
	logic [`ROM_AW-1:0] hdr_off;

	assign cart_beat = beat.wr & cart_download;
	assign beat_a    = beat.addr[`ROM_AW-1:0];
	assign hdr_off   = beat_a - `ROM_AW'(`DL_HDR_BYTES);

	// Image end is one past the last byte written
	assign end_a     = beat_a + 1'b1;

	// ==============================
	// Write handshake
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_q     <= 1'b0;
			ioctl_wait <= 1'b0;
			rom_req    <= 1'b0;
			rom_waddr  <= '0;
		end else begin
			cart_q <= cart_download;
			if (cart_beat) begin
				ioctl_wait <= 1'b1;
				rom_req    <= ~rom_req;
			end else if (ioctl_wait && rom_req == rom_ack) begin
				ioctl_wait <= 1'b0;
				rom_waddr  <= rom_waddr + 1'b1;
			end
			// New image starts at zero
			if (cart_download && !cart_q)
				rom_waddr <= '0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cart_beat)
			rom_wdata <= beat.data;
	end

	// ==============================
	// Masks and flags
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_info <= '0;
		end else begin
			if (cart_beat) begin
				cart_info.size_mask <=
					(beat.addr == '0 ? '0 : cart_info.size_mask) | beat_a;
				cart_info.hdr_mask <=
					(beat.addr == `DL_AW'(`DL_HDR_BYTES) ? '0 : cart_info.hdr_mask) |
					hdr_off;
				cart_info.gg <= beat.idx == 5'(`DL_IDX_GG);
				if (beat.idx == 5'd1 || beat.idx == 5'(`DL_IDX_GG))
					cart_info.arcade <= 1'b0;
			end
			if (beat.wr && beat.kind == kind_sysmode)
				cart_info.arcade <= 1'b1;
			// Odd half-kilobyte end means a copier header
			if (cart_q && !cart_download)
				cart_info.hdr <= end_a[9];
		end
	end

	// Console read translation
	assign mem_raddr = cart_info.hdr ?
		(rom_raddr + `ROM_AW'(`DL_HDR_BYTES)) & cart_info.hdr_mask :
		rom_raddr & cart_info.size_mask;

endmodule

// ==== hw/cheat_assembler.sv ====
// ==============================
// Record offset is the low 4 address bits
// Valid fires on offset 15 whatever came before
// ==============================
`include "dl_defs.svh"

module cheat_assembler (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  dl_pkg::dl_beat_t      beat,
	output dl_pkg::cheat_code_u   code,
	output logic                  code_valid
);
	import dl_pkg::*;

	logic       code_beat;
	logic [3:0] offset;

	assign code_beat = beat.wr && beat.kind == kind_code;
	assign offset    = beat.addr[3:0];

	// ==============================
	// Record fill
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (code_beat)
			code.bytes[offset] <= beat.data;
	end

	// Strobe once the last byte is in
	always_ff @(posedge clk_sys) begin
		if (RESET)
			code_valid <= 1'b0;
		else
			code_valid <= code_beat && offset == 4'd15;
	end

endmodule

// ==== hw/dl_defs.svh ====
// ==============================
// Stream indexes follow the host menu layout
// Any other index is taken as a cartridge image
// ==============================
`ifndef DL_DEFS_SVH
`define DL_DEFS_SVH

// Host stream indexes
`define DL_IDX_SYSMODE 4
`define DL_IDX_DSW     254
`define DL_IDX_CODE    255

// Low index bits of a handheld cartridge
`define DL_IDX_GG      2

// Copier header prepended to some images
`define DL_HDR_BYTES   512

// Address widths
`define DL_AW          25
`define ROM_AW         22

`endif

// ==== hw/dl_pkg.sv ====
// ==============================
// Shared types of the download path
// Cheat words are stored big-endian
// ==============================
`include "dl_defs.svh"

package dl_pkg;

	// Beat kind as decoded from the stream index
	typedef enum logic [2:0] {
		kind_none,
		kind_cart,
		kind_code,
		kind_sysmode,
		kind_dsw
	} dl_kind_e;

	// One registered host write
	typedef struct packed {
		logic             wr;
		dl_kind_e         kind;
		logic [4:0]       idx;
		logic [`DL_AW-1:0] addr;
		logic [7:0]       data;
	} dl_beat_t;

	// Cheat record fields, flags in the top word
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_fields_t;

	// Byte 0 is the most significant byte of the flags
	typedef union packed {
		logic [0:15][7:0] bytes;
		cheat_fields_t    f;
	} cheat_code_u;

	typedef struct packed {
		logic [`ROM_AW-1:0] size_mask;
		logic [`ROM_AW-1:0] hdr_mask;
		logic               hdr;
		logic               gg;
		logic               arcade;
	} cart_info_t;

	typedef struct packed {
		logic [7:0]      sysmode;
		logic [2:0][7:0] dsw;
	} sys_cfg_t;

endpackage

// ==== hw/dl_top.sv ====
// ==============================
// Download path of the console core
// ROM memory and read requester sit outside
// ==============================
`include "dl_defs.svh"

module dl_top (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  ioctl_wr,
	input  logic [`DL_AW-1:0]     ioctl_addr,
	input  logic [7:0]            ioctl_index,
	input  logic [7:0]            ioctl_dout,
	input  logic                  ioctl_download,
	input  logic                  rom_ack,
	input  logic [`ROM_AW-1:0]    rom_raddr,
	output logic                  ioctl_wait,
	output logic                  rom_req,
	output logic [`ROM_AW-1:0]    rom_waddr,
	output logic [7:0]            rom_wdata,
	output logic [`ROM_AW-1:0]    mem_raddr,
	output dl_pkg::cart_info_t    cart_info,
	output dl_pkg::sys_cfg_t      sys_cfg,
	output dl_pkg::cheat_code_u   code,
	output logic                  code_valid
);
	import dl_pkg::*;

	dl_beat_t beat;
	logic     download_q;
	logic     cart_download;

	ioctl_router u_router (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_index    (ioctl_index),
		.ioctl_dout     (ioctl_dout),
		.ioctl_download (ioctl_download),
		.beat           (beat),
		.sys_cfg        (sys_cfg)
	);

	// Download level delayed to line up with the beat
	always_ff @(posedge clk_sys) begin
		if (RESET)
			download_q <= 1'b0;
		else
			download_q <= ioctl_download;
	end

	assign cart_download = download_q && beat.kind == kind_cart;

	cart_loader u_loader (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.beat          (beat),
		.cart_download (cart_download),
		.rom_ack       (rom_ack),
		.rom_raddr     (rom_raddr),
		.ioctl_wait    (ioctl_wait),
		.rom_req       (rom_req),
		.rom_waddr     (rom_waddr),
		.rom_wdata     (rom_wdata),
		.mem_raddr     (mem_raddr),
		.cart_info     (cart_info)
	);

	cheat_assembler u_cheat (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.beat       (beat),
		.code       (code),
		.code_valid (code_valid)
	);

endmodule

// ==== hw/ioctl_router.sv ====
// ==============================
// Kind and index follow the host every cycle
// Address and data are captured on writes only
// ==============================
`include "dl_defs.svh"

module ioctl_router (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  logic                 ioctl_wr,
	input  logic [`DL_AW-1:0]    ioctl_addr,
	input  logic [7:0]           ioctl_index,
	input  logic [7:0]           ioctl_dout,
	input  logic                 ioctl_download,
	output dl_pkg::dl_beat_t     beat,
	output dl_pkg::sys_cfg_t     sys_cfg
);
	import dl_pkg::*;

	dl_kind_e kind_d;

	// Index decode, anything unlisted is a cartridge
	always_comb begin
		case (ioctl_index)
			8'(`DL_IDX_CODE):    kind_d = kind_code;
			8'(`DL_IDX_DSW):     kind_d = kind_dsw;
			8'(`DL_IDX_SYSMODE): kind_d = kind_sysmode;
			default:             kind_d = kind_cart;
		endcase
	end

	// ==============================
	// Beat register
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			beat.wr   <= 1'b0;
			beat.kind <= kind_none;
		end else begin
			beat.wr   <= ioctl_wr;
			beat.kind <= kind_d;
		end
		beat.idx <= ioctl_index[4:0];
		// Payload holds the last written byte
		if (ioctl_wr) begin
			beat.addr <= ioctl_addr;
			beat.data <= ioctl_dout;
		end
	end

	// ==============================
	// System mode and DIP bytes
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			sys_cfg <= '0;
		end else if (beat.wr) begin
			if (beat.kind == kind_sysmode && beat.addr == '0)
				sys_cfg.sysmode <= beat.data;
			// Three DIP banks, the fourth slot is ignored
			if (beat.kind == kind_dsw && beat.addr[`DL_AW-1:2] == '0 &&
					beat.addr[1:0] != 2'd3)
				sys_cfg.dsw[beat.addr[1:0]] <= beat.data;
		end
	end

endmodule

// ==== sim/dl_cases.txt ====
// tag index length base exp0 exp1 exp2 exp3, all hex
// tag 1 cart: size_mask hdr_mask {hdr,gg,arcade}; 2 cheat: code words; 3 config: sys_cfg flags
// Plain cartridge on index 1
1 01 40 00 0000003f 003ffe3f 0 0
// Handheld cartridge on index 2
1 02 12c 5c 000001ff 003fffff 2 0
// System mode sets the arcade flag
3 04 1 5a 5a000000 3 0 0
// Four DIP bytes, the fourth one is dropped
3 fe 4 30 5a323130 3 0 0
// Cheat record
2 ff 10 10 10111213 14151617 18191a1b 1c1d1e1f
// 512 byte header plus 64 byte image on index 1
1 01 240 c3 000003ff 0000003f 4 0
// Second cheat record overwrites the first
2 ff 10 a0 a0a1a2a3 a4a5a6a7 a8a9aaab acadaeaf

// ==== sim/dl_props.sv ====
// ==============================
// Bound into loader and cheat assembler
// Inputs a module lacks are tied low at the bind
// ==============================
module dl_props (
	input logic clk_sys,
	input logic RESET,
	input logic ioctl_wait,
	input logic rom_req,
	input logic code_valid
);
	timeunit 1ns;
	timeprecision 100ps;

	// Request toggles only together with the wait level
	req_with_wait: assert property (@(posedge clk_sys) disable iff (RESET)
		$changed(rom_req) |-> ioctl_wait)
		else $error("rom_req changed while ioctl_wait was low");

	valid_single: assert property (@(posedge clk_sys) disable iff (RESET)
		code_valid |=> !code_valid)
		else $error("code_valid high for two cycles in a row");

	wait_after_reset: assert property (@(posedge clk_sys)
		$fell(RESET) |-> !ioctl_wait)
		else $error("ioctl_wait high right after reset");

endmodule

bind cart_loader dl_props u_loader_props (
	.clk_sys    (clk_sys),
	.RESET      (RESET),
	.ioctl_wait (ioctl_wait),
	.rom_req    (rom_req),
	.code_valid (1'b0)
);

bind cheat_assembler dl_props u_cheat_props (
	.clk_sys    (clk_sys),
	.RESET      (RESET),
	.ioctl_wait (1'b0),
	.rom_req    (1'b0),
	.code_valid (code_valid)
);

// ==== sim/tb_dl_top.sv ====
// ==============================
// Host strobes one byte at a time and honors ioctl_wait
// Memory acks 0 to 3 cycles after each request
// ==============================
`include "dl_defs.svh"

module tb_dl_top;
	timeunit 1ns;
	timeprecision 100ps;

	import dl_pkg::*;

	localparam int MAX_CASES = 16;
	localparam int WORDS     = 8;
	localparam int ACK_MAX   = 3;

	logic               clk_sys = 1'b0;
	logic               RESET;
	logic               ioctl_wr;
	logic [`DL_AW-1:0]  ioctl_addr;
	logic [7:0]         ioctl_index;
	logic [7:0]         ioctl_dout;
	logic               ioctl_download;
	logic               rom_ack = 1'b0;
	logic [`ROM_AW-1:0] rom_raddr;
	logic               ioctl_wait;
	logic               rom_req;
	logic [`ROM_AW-1:0] rom_waddr;
	logic [7:0]         rom_wdata;
	logic [`ROM_AW-1:0] mem_raddr;
	cart_info_t         cart_info;
	sys_cfg_t           sys_cfg;
	cheat_code_u        code;
	logic               code_valid;

	logic [31:0]        case_mem [0:MAX_CASES*WORDS-1];
	cart_info_t         exp_info;
	sys_cfg_t           exp_cfg;
	logic [`ROM_AW-1:0] exp_waddr;
	logic [7:0]         exp_wdata;
	logic [7:0]         lfsr = 8'd24;
	logic [1:0]         ack_left;
	bit                 ack_busy = 1'b0;
	int unsigned        writes;
	int unsigned        valid_pulses;
	int unsigned        cycle_count = 0;
	int unsigned        cycle_limit;

	dl_top DUT (.*);

	always #5 clk_sys = ~clk_sys;

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Run stopped at first failure");
	endtask

	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
	endfunction

	task automatic draw_ack_delay(output logic [1:0] d);
		for (int i = 0; i < 2; i++) begin
			d = {d[0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// Stream byte depends on every address bit
	function automatic logic [7:0] stream_byte(input logic [7:0] base,
			input logic [`DL_AW-1:0] a);
		return base ^ a[7:0] ^ a[15:8] ^ a[23:16] ^ {7'b0, a[24]};
	endfunction

	// ==============================
	// Compare tasks
	// ==============================
	task automatic check_info(input cart_info_t got, input cart_info_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("** Error at %0t: cart_info got %h, expected %h",
				$time, got, exp));
	endtask

	task automatic check_cfg(input sys_cfg_t got, input sys_cfg_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("** Error at %0t: sys_cfg got %h, expected %h",
				$time, got, exp));
	endtask

	task automatic check_code(input cheat_code_u got, input cheat_code_u exp);
		if (got !== exp)
			stop_with_failure($sformatf("** Error at %0t: code got %h, expected %h",
				$time, got, exp));
	endtask

	task automatic check_rom_write(input logic [`ROM_AW-1:0] got_a, input logic [7:0] got_d,
			input logic [`ROM_AW-1:0] exp_a, input logic [7:0] exp_d);
		if (got_a !== exp_a || got_d !== exp_d)
			stop_with_failure($sformatf(
				"** Error at %0t: rom_waddr/rom_wdata got %h/%h, expected %h/%h",
				$time, got_a, got_d, exp_a, exp_d));
	endtask

	task automatic check_read_addr(input logic [`ROM_AW-1:0] got,
			input logic [`ROM_AW-1:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("** Error at %0t: mem_raddr got %h, expected %h",
				$time, got, exp));
	endtask

	// All driving and sampling happens 1 ns after the edge
	task automatic tick();
		@(posedge clk_sys);
		#1;
		if (code_valid === 1'b1)
			valid_pulses++;
	endtask

	// ==============================
	// Memory model and timeout
	// ==============================
	always @(posedge clk_sys) begin
		#1;
		if (rom_req != rom_ack) begin
			if (!ack_busy) begin
				draw_ack_delay(ack_left);
				ack_busy = 1'b1;
			end
			if (ack_left == 2'd0) begin
				check_rom_write(rom_waddr, rom_wdata, exp_waddr, exp_wdata);
				writes++;
				rom_ack = rom_req;
				ack_busy = 1'b0;
			end else begin
				ack_left--;
			end
		end
	end

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count > cycle_limit)
			stop_with_failure($sformatf("Run timed out after %0d clock cycles", cycle_count));
	end

	task automatic send_stream(input logic [7:0] idx, input int unsigned len,
			input logic [7:0] base, input bit is_cart);
		logic [`DL_AW-1:0] a;
		ioctl_index = idx;
		ioctl_download = 1'b1;
		writes = 0;
		// Let the delayed download level and the address restart settle
		tick();
		tick();
		for (int unsigned n = 0; n < len; n++) begin
			a = `DL_AW'(n);
			ioctl_addr = a;
			ioctl_dout = stream_byte(base, a);
			exp_waddr = a[`ROM_AW-1:0];
			exp_wdata = stream_byte(base, a);
			ioctl_wr = 1'b1;
			tick();
			ioctl_wr = 1'b0;
			tick();
			if (is_cart) begin
				if (ioctl_wait !== 1'b1)
					stop_with_failure("ioctl_wait did not rise after a cartridge byte");
				while (ioctl_wait)
					tick();
				if (writes != n + 1)
					stop_with_failure("ioctl_wait fell before the memory acknowledged");
			end
		end
		ioctl_download = 1'b0;
		repeat (3) tick();
	endtask

	task automatic check_read_map();
		logic [`ROM_AW-1:0] r;
		logic [`ROM_AW-1:0] exp_a;
		for (int i = 0; i < 3; i++) begin
			r = (i == 0) ? 22'h000013 : (i == 1) ? 22'h0001A5 : 22'h2ABCDE;
			exp_a = exp_info.hdr ? (r + 22'd512) & exp_info.hdr_mask :
				r & exp_info.size_mask;
			rom_raddr = r;
			tick();
			check_read_addr(mem_raddr, exp_a);
		end
	endtask

	// Words are tag, index, length, base, then four expected values
	task automatic run_case(input int c);
		logic [31:0] w [0:WORDS-1];
		cheat_code_u exp_code;
		for (int i = 0; i < WORDS; i++)
			w[i] = case_mem[c*WORDS+i];
		if (w[0] < 1 || w[0] > 3)
			stop_with_failure($sformatf("Case %0d has an unknown tag %0h", c, w[0]));
		valid_pulses = 0;
		send_stream(w[1][7:0], w[2], w[3][7:0], w[0] == 1);
		if (w[0] == 1) begin
			exp_info.size_mask = w[4][`ROM_AW-1:0];
			exp_info.hdr_mask = w[5][`ROM_AW-1:0];
			{exp_info.hdr, exp_info.gg, exp_info.arcade} = w[6][2:0];
		end else if (w[0] == 3) begin
			exp_cfg = w[4];
			{exp_info.hdr, exp_info.gg, exp_info.arcade} = w[5][2:0];
		end
		check_info(cart_info, exp_info);
		check_cfg(sys_cfg, exp_cfg);
		if (w[0] == 2) begin
			exp_code.f = {w[4], w[5], w[6], w[7]};
			check_code(code, exp_code);
		end
		if (valid_pulses != ((w[0] == 2) ? 1 : 0))
			stop_with_failure($sformatf("Case %0d saw %0d code_valid pulses", c, valid_pulses));
		if (w[0] == 1)
			check_read_map();
	endtask

	initial begin
		int unsigned n_bytes;
		int          n_cases;
		RESET = 1'b1;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_index = '0;
		ioctl_dout = '0;
		ioctl_download = 1'b0;
		rom_raddr = '0;
		exp_info = '0;
		exp_cfg = '0;
		for (int i = 0; i < MAX_CASES*WORDS; i++)
			case_mem[i] = '0;
		$readmemh("sim/dl_cases.txt", case_mem);
		n_bytes = 0;
		n_cases = 0;
		while (n_cases < MAX_CASES && case_mem[n_cases*WORDS] != 0) begin
			n_bytes += case_mem[n_cases*WORDS+2];
			n_cases++;
		end
		cycle_limit = 20 * n_bytes * ACK_MAX;
		if (n_cases == 0)
			stop_with_failure("No cases could be read from sim/dl_cases.txt");
		repeat (5) tick();
		RESET = 1'b0;
		tick();
		for (int c = 0; c < n_cases; c++)
			run_case(c);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule
